/* lin_pkg.sv */
package lin_pkg;

    // Galois LFSR, right shifting form:
    //   next = lsb ? (state >> 1) ^ LFSR_TAPS : state >> 1
    // Polynomial taps 64, 63, 61, 60 map to bits 63, 62, 60, 59
    localparam logic [63:0] LFSR_TAPS = 64'hD800_0000_0000_0000;

    localparam int CNT_W = 16;                        // Width of count and sample tally

    // Default linear masks for the analysis
    localparam logic [63:0] DEFAULT_MASK_IN  = 64'h0000_0021_0000_0400;   // Plaintext side
    localparam logic [63:0] DEFAULT_MASK_OUT = 64'h0000_0400_0000_0021;   // Ciphertext side

endpackage

/* cipher_pkg.sv */
package cipher_pkg;

    typedef logic [31:0] half_t;                      // One Feistel half

    typedef union packed {
        logic [63:0] word;                            // Whole block, used by mask parity
        struct packed {
            half_t left;                              // Upper 32 bits
            half_t right;                             // Lower 32 bits
        } halves;                                     // Split view, used by the rounds
    } block_t;

    // PRESENT S-box, entry i sits at bits [4*i +: 4]
    localparam logic [63:0] SBOX_TABLE = 64'h2174_8FE3_DA09_B65C;

    function automatic logic [3:0] sbox(input logic [3:0] nib);
        return SBOX_TABLE[4*nib +: 4];                // Table lookup
    endfunction

    function automatic half_t round_key(input logic [63:0] key, input int idx);
        logic [127:0] dbl;                            // Key twice, for the rotation
        logic [5:0]   amt;                            // Rotation amount mod 64
        amt = 6'((7 * idx) % 64);
        dbl = {key, key} << amt;                      // Upper half is key rotated left
        return dbl[95:64];                            // Low 32 bits of rotated key
    endfunction

    function automatic half_t feistel_f(input half_t r, input half_t k);
        half_t x;                                     // Keyed input
        half_t y;                                     // After substitution
        x = r ^ k;
        for (int n = 0; n < 8; n++) begin
            y[4*n +: 4] = sbox(x[4*n +: 4]);          // Same S-box on every nibble
        end
        return {y[28:0], y[31:29]};                   // Rotate left by 3
    endfunction

endpackage

/* message_lfsr.sv */
`timescale 1ns/1ps

module message_lfsr (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                start,               // Load pulse
    input  logic [63:0]         seed,
    output cipher_pkg::block_t  message,
    output logic                message_valid
);

    import lin_pkg::*;

    logic [63:0] lfsr_q;                              // Generator state, no reset
    logic        running_q;                           // Set once seeded

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            running_q <= 1'b0;
        end else if (start && !running_q) begin
            running_q <= 1'b1;                        // Later starts are ignored
        end
    end

    always_ff @(posedge clk) begin
        if (start && !running_q) begin
            lfsr_q <= (seed == 64'd0) ? 64'd1 : seed; // All-zero state would lock up
        end else if (running_q) begin
            if (lfsr_q[0]) begin
                lfsr_q <= (lfsr_q >> 1) ^ LFSR_TAPS;  // Feedback into tap bits
            end else begin
                lfsr_q <= lfsr_q >> 1;
            end
        end
    end

    assign message.word  = lfsr_q;                    // New plaintext every cycle
    assign message_valid = running_q;

endmodule

/* feistel_pipeline.sv */
`timescale 1ns/1ps

module feistel_pipeline #(
    parameter int NUM_ROUNDS = 4                      // One round per stage
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic [63:0]         key,
    input  cipher_pkg::block_t  message,
    input  logic                message_valid,
    output cipher_pkg::block_t  ciphertext,
    output logic                ciphertext_valid
);

    import cipher_pkg::*;

    block_t                  stage_in [NUM_ROUNDS];   // Input of each round
    block_t                  stage_q  [NUM_ROUNDS];   // Stage registers, payload only
    logic [NUM_ROUNDS-1:0]   valid_q;                 // Valid bit per stage

    // Round i reads the previous stage, round 0 reads the message
    always_comb begin
        stage_in[0] = message;
        for (int i = 1; i < NUM_ROUNDS; i++) begin
            stage_in[i] = stage_q[i-1];
        end
    end

    // Feistel round: L' = R, R' = L ^ F(R, K_i)
    always_ff @(posedge clk) begin
        for (int i = 0; i < NUM_ROUNDS; i++) begin
            stage_q[i].halves.left  <= stage_in[i].halves.right;
            stage_q[i].halves.right <= stage_in[i].halves.left
                                     ^ feistel_f(stage_in[i].halves.right,
                                                 round_key(key, i));
        end
    end

    // Valid travels alongside the data
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else begin
            valid_q[0] <= message_valid;
            for (int i = 1; i < NUM_ROUNDS; i++) begin
                valid_q[i] <= valid_q[i-1];
            end
        end
    end

    assign ciphertext       = stage_q[NUM_ROUNDS-1];  // Last round output
    assign ciphertext_valid = valid_q[NUM_ROUNDS-1];  // NUM_ROUNDS cycles after message_valid

endmodule

/* mask_delay_line.sv */
`timescale 1ns/1ps

module mask_delay_line #(
    parameter int          NUM_ROUNDS = 4,                       // Must match pipeline depth
    parameter logic [63:0] MASK_IN    = lin_pkg::DEFAULT_MASK_IN
) (
    input  logic                clk,
    input  logic                rst_n,
    input  cipher_pkg::block_t  message,
    input  logic                message_valid,
    output logic                in_parity_aligned
);

    logic                  in_parity;                 // Parity of masked plaintext
    logic [NUM_ROUNDS-1:0] parity_q;                  // Bit 0 newest, top bit oldest

    assign in_parity = ^(message.word & MASK_IN);     // Input-mask dot product

    // Shifts only with the stream so it stays in step with the pipeline
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            parity_q <= '0;
        end else if (message_valid) begin
            parity_q[0] <= in_parity;
            for (int i = 1; i < NUM_ROUNDS; i++) begin
                parity_q[i] <= parity_q[i-1];
            end
        end
    end

    assign in_parity_aligned = parity_q[NUM_ROUNDS-1]; // Belongs to the block now leaving

endmodule

/* bias_counter.sv */
`timescale 1ns/1ps

module bias_counter #(
    parameter logic [63:0] MASK_OUT    = lin_pkg::DEFAULT_MASK_OUT,
    parameter int unsigned NUM_SAMPLES = 200          // Must fit in CNT_W
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        start,
    input  cipher_pkg::block_t          ciphertext,
    input  logic                        ciphertext_valid,
    input  logic                        in_parity_aligned,
    output logic [lin_pkg::CNT_W-1:0]   count,        // Number of ones seen
    output logic                        done
);

    import lin_pkg::*;

    localparam logic [1:0] ST_IDLE  = 2'd0;           // Waiting for start
    localparam logic [1:0] ST_COUNT = 2'd1;           // Accumulating samples
    localparam logic [1:0] ST_DONE  = 2'd2;           // Result held

    logic [1:0]       state_q;
    logic             out_parity;                     // Parity of masked ciphertext
    logic             result_q;                       // Registered approximation bit
    logic             sample_q;                       // result_q holds a new sample
    logic [CNT_W-1:0] tally_q;                        // Samples consumed so far

    assign out_parity = ^(ciphertext.word & MASK_OUT);

    always_ff @(posedge clk) begin
        if (ciphertext_valid) begin
            result_q <= out_parity ^ in_parity_aligned;   // 1 when the relation fails
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q  <= ST_IDLE;
            sample_q <= 1'b0;
            tally_q  <= '0;
            count    <= '0;
        end else begin
            sample_q <= (state_q == ST_COUNT) && ciphertext_valid;
            case (state_q)
                ST_IDLE: begin
                    if (start) begin
                        state_q <= ST_COUNT;
                    end
                end
                ST_COUNT: begin
                    if (sample_q) begin
                        tally_q <= tally_q + 1'b1;
                        count   <= count + {{(CNT_W-1){1'b0}}, result_q};
                        if (tally_q == CNT_W'(NUM_SAMPLES - 1)) begin
                            state_q <= ST_DONE;       // Last sample just counted
                        end
                    end
                end
                ST_DONE: begin
                    state_q <= ST_DONE;               // Only reset leaves
                end
                default: begin
                    state_q <= ST_IDLE;
                end
            endcase
        end
    end

    assign done = (state_q == ST_DONE);

endmodule

/* linear_bias_top.sv */
`timescale 1ns/1ps

module linear_bias_top #(
    parameter int          NUM_ROUNDS  = 4,
    parameter logic [63:0] MASK_IN     = lin_pkg::DEFAULT_MASK_IN,
    parameter logic [63:0] MASK_OUT    = lin_pkg::DEFAULT_MASK_OUT,
    parameter int unsigned NUM_SAMPLES = 200
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        start,        // One-cycle pulse
    input  logic [63:0]                 seed,
    input  logic [63:0]                 key,
    output logic [lin_pkg::CNT_W-1:0]   count,
    output logic                        done
);

    import cipher_pkg::*;

    block_t message;                                  // Plaintext stream
    logic   message_valid;
    block_t ciphertext;                               // Pipeline output
    logic   ciphertext_valid;
    logic   in_parity_aligned;                        // Input-mask bit matched to ciphertext

    message_lfsr u_lfsr (
        .clk            (clk),
        .rst_n          (rst_n),
        .start          (start),
        .seed           (seed),
        .message        (message),
        .message_valid  (message_valid)
    );

    feistel_pipeline #(
        .NUM_ROUNDS (NUM_ROUNDS)
    ) u_cipher (
        .clk              (clk),
        .rst_n            (rst_n),
        .key              (key),
        .message          (message),
        .message_valid    (message_valid),
        .ciphertext       (ciphertext),
        .ciphertext_valid (ciphertext_valid)
    );

    mask_delay_line #(
        .NUM_ROUNDS (NUM_ROUNDS),                     // Same depth as the cipher
        .MASK_IN    (MASK_IN)
    ) u_delay (
        .clk               (clk),
        .rst_n             (rst_n),
        .message           (message),
        .message_valid     (message_valid),
        .in_parity_aligned (in_parity_aligned)
    );

    bias_counter #(
        .MASK_OUT    (MASK_OUT),
        .NUM_SAMPLES (NUM_SAMPLES)
    ) u_counter (
        .clk               (clk),
        .rst_n             (rst_n),
        .start             (start),
        .ciphertext        (ciphertext),
        .ciphertext_valid  (ciphertext_valid),
        .in_parity_aligned (in_parity_aligned),
        .count             (count),
        .done              (done)
    );

endmodule

/* bias_chk.sv */
`timescale 1ns/1ps

module bias_chk #(
    parameter int unsigned NUM_SAMPLES = 200
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        done,
    input  logic [lin_pkg::CNT_W-1:0]   count
);

    import lin_pkg::*;

    int error_count = 0;                              // Failed assertions so far

    reset_clears: assert property (@(posedge clk) !rst_n |=> (!done && count == '0))
        else begin
            $error("done or count not cleared one cycle after reset");
            error_count++;
        end

    done_sticky: assert property (@(posedge clk) (rst_n && done) |=> done)
        else begin
            $error("done dropped without a reset");
            error_count++;
        end

    count_in_range: assert property (@(posedge clk) disable iff (!rst_n)
                                     count <= CNT_W'(NUM_SAMPLES))
        else begin
            $error("count above the number of samples");
            error_count++;
        end

    count_frozen: assert property (@(posedge clk) (rst_n && done) |=> $stable(count))
        else begin
            $error("count changed while done was high");
            error_count++;
        end

endmodule

/* bias_monitor.sv */
`timescale 1ns/1ps

module bias_monitor (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        done,
    input  logic [lin_pkg::CNT_W-1:0]   count,
    input  logic [lin_pkg::CNT_W-1:0]   expected,     // From the trace
    input  logic [127:0]                test_name,
    input  logic                        test_end,     // Closes the current test
    output int                          pass_count,
    output int                          fail_count
);

    import lin_pkg::*;

    logic             rst_q     = 1'b0;               // rst_n one cycle ago
    logic             done_q    = 1'b0;
    logic [CNT_W-1:0] held      = '0;                 // Count captured at done
    logic             seen_done = 1'b0;
    logic             failed    = 1'b0;               // Any check of this test failed
    int               passes    = 0;
    int               fails     = 0;

    always @(posedge clk) begin
        rst_q  <= rst_n;
        done_q <= done;
        if (rst_n && !rst_q && (done || count != '0)) begin   // First cycle out of reset
            $display("Error in %0s: done or count not cleared by reset", test_name);
            failed = 1'b1;
        end
        if (rst_n && done && !done_q) begin
            held      = count;
            seen_done = 1'b1;
            if (count !== expected) begin
                $display("Mismatch in %0s: expected %0d, actual %0d",
                         test_name, expected, count);
                failed = 1'b1;
            end
        end else if (rst_n && done && count !== held) begin
            $display("Error in %0s: count moved from %0d to %0d after done",
                     test_name, held, count);
            held   = count;
            failed = 1'b1;
        end
        if (test_end) begin
            if (!seen_done) begin
                $display("Error in %0s: done never rose", test_name);
                failed = 1'b1;
            end
            if (failed) begin
                fails++;
                $display("Test %0s failed", test_name);
            end else begin
                passes++;
                $display("Test %0s passed, count %0d", test_name, held);
            end
            failed    = 1'b0;
            seen_done = 1'b0;
        end
    end

    assign pass_count = passes;
    assign fail_count = fails;

endmodule

/* tb_linear_bias.sv */
`timescale 1ns/1ps

module tb_linear_bias;

    import lin_pkg::*;

    localparam int          NUM_ROUNDS  = 4;
    localparam int unsigned NUM_SAMPLES = 200;
    localparam logic [63:0] MASK_IN     = 64'h1;      // Plaintext lsb, the LFSR output bit
    localparam logic [63:0] MASK_OUT    = 64'h0;      // Ciphertext side not used
    localparam int          HOLD_CYCLES = 50;         // Cycles watched after done
    localparam int          CLK_PERIOD  = 20;
    localparam int          SLOT_CYCLES = NUM_SAMPLES + NUM_ROUNDS + HOLD_CYCLES + 40;

    logic             clk;
    logic             rst_n;
    logic             start;
    logic [63:0]      seed;
    logic [63:0]      key;
    logic [CNT_W-1:0] count;
    logic             done;

    logic [127:0]     cur_name;                       // Current test, for the monitor
    logic [CNT_W-1:0] cur_expected;
    logic             test_end;                       // One-cycle pulse closing a test
    int               passes;
    int               fails;

    logic [127:0]     name_q[$];                      // Trace columns
    logic [63:0]      seed_q[$];
    logic [63:0]      key_q[$];
    logic [CNT_W-1:0] expect_q[$];
    int               num_tests = 0;

    linear_bias_top #(
        .NUM_ROUNDS  (NUM_ROUNDS),
        .MASK_IN     (MASK_IN),
        .MASK_OUT    (MASK_OUT),
        .NUM_SAMPLES (NUM_SAMPLES)
    ) UUT (
        .clk   (clk),
        .rst_n (rst_n),
        .start (start),
        .seed  (seed),
        .key   (key),
        .count (count),
        .done  (done)
    );

    bind linear_bias_top bias_chk #(.NUM_SAMPLES(NUM_SAMPLES)) u_chk (
        .clk   (clk),
        .rst_n (rst_n),
        .done  (done),
        .count (count)
    );

    bias_monitor u_monitor (
        .clk        (clk),
        .rst_n      (rst_n),
        .done       (done),
        .count      (count),
        .expected   (cur_expected),
        .test_name  (cur_name),
        .test_end   (test_end),
        .pass_count (passes),
        .fail_count (fails)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Name, seed, key and expected count per non-comment line
    task automatic load_trace();
        int           fd;
        string        line;
        logic [127:0] name;
        logic [63:0]  s;
        logic [63:0]  k;
        int           e;
        fd = $fopen("bias_trace.txt", "r");
        if (fd == 0) begin
            $display("Could not open bias_trace.txt");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 1 && line.getc(0) != "#") begin
                    if ($sscanf(line, "%s %h %h %d", name, s, k, e) == 4) begin
                        name_q.push_back(name);
                        seed_q.push_back(s);
                        key_q.push_back(k);
                        expect_q.push_back(CNT_W'(e));
                    end
                end
            end
            $fclose(fd);
            num_tests = name_q.size();
        end
    endtask

    task automatic run_test(input int idx);
        int idle;
        idle = int'($urandom % 6);                    // 0 to 5 idle cycles before start
        @(posedge clk);
        rst_n        <= 1'b0;
        seed         <= seed_q[idx];
        key          <= key_q[idx];
        cur_name     <= name_q[idx];
        cur_expected <= expect_q[idx];
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        repeat (idle) @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        do @(posedge clk); while (!done);
        for (int n = 0; n < HOLD_CYCLES; n++) begin
            @(posedge clk);
            start <= (n == HOLD_CYCLES / 2);          // Late start, must not disturb count
        end
        test_end <= 1'b1;
        @(posedge clk);
        test_end <= 1'b0;
        @(posedge clk);                               // Monitor tallies the test here
    endtask

    initial begin
        rst_n        = 1'b0;
        start        = 1'b0;
        seed         = '0;
        key          = '0;
        cur_name     = '0;
        cur_expected = '0;
        test_end     = 1'b0;
        void'($urandom(79885));
        load_trace();
        if (num_tests == 0) begin
            $display("No test lines read from the trace file");
        end
        for (int t = 0; t < num_tests; t++) begin
            run_test(t);
        end
        $display("Tests: %0d, passed: %0d, failed: %0d, assertion failures: %0d",
                 num_tests, passes, fails, UUT.u_chk.error_count);
        if (num_tests > 0 && fails == 0 && passes == num_tests
                && UUT.u_chk.error_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    // Watchdog sized from the number of tests in the trace
    initial begin
        wait (num_tests > 0);
        #(num_tests * SLOT_CYCLES * CLK_PERIOD);
        $display("Timeout: the tests did not finish in %0d cycles", num_tests * SLOT_CYCLES);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

/* bias_trace.txt */
# name  seed(hex)  key(hex)  expected_count(decimal)
# count of ones in plaintext bit 0 over 200 samples, seeds are powers of two
seed_one     0000000000000001 0123456789abcdef 19
seed_zero    0000000000000000 0123456789abcdef 19
seed_bit4    0000000000000010 fedcba9876543210 19
seed_bit8    0000000000000100 0f1e2d3c4b5a6978 18
seed_bit10   0000000000000400 a5a5a5a5a5a5a5a5 16
seed_bit16   0000000000010000 ffffffffffffffff 12
seed_bit20   0000000000100000 0000000000000000 9

/* compile.f */
lin_pkg.sv
cipher_pkg.sv
message_lfsr.sv
feistel_pipeline.sv
mask_delay_line.sv
bias_counter.sv
linear_bias_top.sv
bias_chk.sv
bias_monitor.sv
tb_linear_bias.sv

/* Makefile */
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_linear_bias \
		-Mdir obj_dir -f compile.f
	@out="$$(./obj_dir/Vtb_linear_bias)"; echo "$$out"; \
	echo "$$out" | grep -q "^RESULT: PASS$$"

clean:
	rm -rf obj_dir
